// ==== project.f ====
+incdir+logic
logic/la_decode_pkg.sv
logic/la_pipe_pkg.sv
logic/exe_if.sv
logic/credit_fifo.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/alu.sv
logic/exec_stage.sv
logic/la_exec_top.sv
test/tb_la_exec.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LoongArch execute pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module tb_la_exec \
    -o sim_la_exec

./obj_dir/sim_la_exec | tee sim.log

# The run passes only if the testbench printed its pass line
grep -q "^STATUS: PASS$" sim.log
echo "Simulation passed"

// ==== test/tb_la_exec.sv ====
`timescale 1ns/1ps
`include "la_consts.svh"

module tb_la_exec import la_pipe_pkg::*; ();

// Opcode fields of the LoongArch-32 subset
localparam logic [16:0] op_add_w   = 17'h00020;
localparam logic [16:0] op_sub_w   = 17'h00022;
localparam logic [16:0] op_slt     = 17'h00024;
localparam logic [16:0] op_sltu    = 17'h00025;
localparam logic [16:0] op_nor     = 17'h00028;
localparam logic [16:0] op_and     = 17'h00029;
localparam logic [16:0] op_or      = 17'h0002a;
localparam logic [16:0] op_xor     = 17'h0002b;
localparam logic [16:0] op_sll_w   = 17'h0002e;
localparam logic [16:0] op_srl_w   = 17'h0002f;
localparam logic [16:0] op_sra_w   = 17'h00030;
localparam logic [16:0] op_mul_w   = 17'h00038;
localparam logic [16:0] op_mulh_w  = 17'h00039;
localparam logic [16:0] op_mulh_wu = 17'h0003a;
localparam logic [16:0] op_div_w   = 17'h00040;
localparam logic [16:0] op_mod_w   = 17'h00041;
localparam logic [16:0] op_div_wu  = 17'h00042;
localparam logic [16:0] op_mod_wu  = 17'h00043;
localparam logic [16:0] op_slli_w  = 17'h00081;
localparam logic [16:0] op_srli_w  = 17'h00089;
localparam logic [16:0] op_srai_w  = 17'h00091;
localparam logic [9:0]  op_slti    = 10'h008;
localparam logic [9:0]  op_sltui   = 10'h009;
localparam logic [9:0]  op_addi_w  = 10'h00a;
localparam logic [9:0]  op_andi    = 10'h00d;
localparam logic [9:0]  op_ori     = 10'h00e;
localparam logic [9:0]  op_xori    = 10'h00f;
localparam logic [6:0]  op_lu12i_w   = 7'h0a;
localparam logic [6:0]  op_pcaddu12i = 7'h0e;

logic     clk_i;
logic     rst_n_i;
logic     inst_valid_i;
word_t    inst_i;
word_t    pc_i;
logic     inst_credit_o;
logic     res_credit_i;
logic     res_valid_o;
reg_idx_t res_rd_o;
word_t    res_data_o;
word_t    res_pc_o;
logic     res_illegal_o;

word_t   model_regs [`_NREG];
result_t exp_q [$];
string   cur_test;
int      stim_seed;
int      gap_seed;
int      credit_used;
int      credit_ret;
int      res_seen;
int      res_ret;
int      owed;
int      cycles;
int      err_count;
int      err_start;
int      res_checked;
int      chk_start;
int      tests_run;
logic    hold_credits;
word_t   pc_next;

la_exec_top i_la_exec_top (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .inst_valid_i  (inst_valid_i),
    .inst_i        (inst_i),
    .pc_i          (pc_i),
    .inst_credit_o (inst_credit_o),
    .res_credit_i  (res_credit_i),
    .res_valid_o   (res_valid_o),
    .res_rd_o      (res_rd_o),
    .res_data_o    (res_data_o),
    .res_pc_o      (res_pc_o),
    .res_illegal_o (res_illegal_o)
);

initial clk_i = 1'b0;
always #50 clk_i = ~clk_i;

function automatic word_t enc_3r(input logic [16:0] op, input reg_idx_t rd,
                                 input reg_idx_t rj, input reg_idx_t rk);
    return {op, rk, rj, rd};
endfunction

function automatic word_t enc_2ri12(input logic [9:0] op, input reg_idx_t rd,
                                    input reg_idx_t rj, input logic [11:0] imm);
    return {op, imm, rj, rd};
endfunction

function automatic word_t enc_1ri20(input logic [6:0] op, input reg_idx_t rd,
                                    input logic [19:0] imm);
    return {op, imm, rd};
endfunction

function automatic word_t rand_word();
    return word_t'($random(stim_seed));
endfunction

function automatic word_t sra_word(input word_t a, input logic [4:0] sh);
    return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
endfunction

// Works on magnitudes and fixes the signs afterwards
function automatic word_t model_div(input word_t a, input word_t b, input logic sgn,
                                   input logic rem);
    word_t ma;
    word_t mb;
    word_t q;
    word_t r;
    if (b == 32'd0) begin
        return rem ? a : 32'hffff_ffff;
    end
    if (sgn && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
        return rem ? 32'd0 : 32'h8000_0000;
    end
    ma = (sgn && a[31]) ? -a : a;
    mb = (sgn && b[31]) ? -b : b;
    q = ma / mb;
    r = ma % mb;
    if (sgn && (a[31] ^ b[31])) begin
        q = -q;
    end
    if (sgn && a[31]) begin
        r = -r;
    end
    return rem ? r : q;
endfunction

function automatic result_t model_result(input word_t inst, input word_t pc);
    result_t     r;
    word_t       a;
    word_t       b;
    word_t       si12;
    word_t       ui12;
    word_t       si20;
    logic [63:0] ps;
    logic [63:0] pu;
    a = model_regs[inst[9:5]];
    b = model_regs[inst[14:10]];
    si12 = {{20{inst[21]}}, inst[21:10]};
    ui12 = {20'd0, inst[21:10]};
    si20 = {inst[24:5], 12'd0};
    // Low 64 bits of a product of sign-extended operands equal the signed product
    ps = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    pu = {32'd0, a} * {32'd0, b};
    r = '{rd: inst[4:0], data: 32'd0, pc: pc, illegal: 1'b0};
    if (inst[31:25] == op_lu12i_w) begin
        r.data = si20;
    end else if (inst[31:25] == op_pcaddu12i) begin
        r.data = pc + si20;
    end else begin
        case (inst[31:22])
            op_slti:   r.data = {31'd0, (a ^ 32'h8000_0000) < (si12 ^ 32'h8000_0000)};
            op_sltui:  r.data = {31'd0, a < si12};
            op_addi_w: r.data = a + si12;
            op_andi:   r.data = a & ui12;
            op_ori:    r.data = a | ui12;
            op_xori:   r.data = a ^ ui12;
            default: begin
                case (inst[31:15])
                    op_add_w:   r.data = a + b;
                    op_sub_w:   r.data = a - b;
                    op_slt:     r.data = {31'd0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
                    op_sltu:    r.data = {31'd0, a < b};
                    op_nor:     r.data = ~(a | b);
                    op_and:     r.data = a & b;
                    op_or:      r.data = a | b;
                    op_xor:     r.data = a ^ b;
                    op_sll_w:   r.data = a << b[4:0];
                    op_srl_w:   r.data = a >> b[4:0];
                    op_sra_w:   r.data = sra_word(a, b[4:0]);
                    op_mul_w:   r.data = ps[31:0];
                    op_mulh_w:  r.data = ps[63:32];
                    op_mulh_wu: r.data = pu[63:32];
                    op_div_w:   r.data = model_div(a, b, 1'b1, 1'b0);
                    op_mod_w:   r.data = model_div(a, b, 1'b1, 1'b1);
                    op_div_wu:  r.data = model_div(a, b, 1'b0, 1'b0);
                    op_mod_wu:  r.data = model_div(a, b, 1'b0, 1'b1);
                    op_slli_w:  r.data = a << inst[14:10];
                    op_srli_w:  r.data = a >> inst[14:10];
                    op_srai_w:  r.data = sra_word(a, inst[14:10]);
                    default:    r = '{rd: 5'd0, data: 32'd0, pc: pc, illegal: 1'b1};
                endcase
            end
        endcase
    end
    return r;
endfunction

task automatic check_word(input string what, input word_t exp, input word_t got);
    if (got !== exp) begin
        $display("ERR %s %s: expected %h, actual %h", cur_test, what, exp, got);
        err_count++;
    end
endtask

task automatic check_result(input result_t exp, input result_t got);
    res_checked++;
    if (got.rd !== exp.rd || got.pc !== exp.pc || got.illegal !== exp.illegal) begin
        $display("ERR %s result: expected rd %0d pc %h illegal %b, actual rd %0d pc %h illegal %b",
                 cur_test, exp.rd, exp.pc, exp.illegal, got.rd, got.pc, got.illegal);
        err_count++;
    end
    check_word("data", exp.data, got.data);
endtask

// Waits for an input credit, drives one word and records what it must produce
task automatic send_inst(input word_t inst, input word_t pc);
    result_t exp;
    @(posedge clk_i);
    while (`_IN_DEPTH + credit_ret - credit_used <= 0) begin
        inst_valid_i <= 1'b0;
        @(posedge clk_i);
    end
    inst_valid_i <= 1'b1;
    inst_i <= inst;
    pc_i <= pc;
    credit_used++;
    exp = model_result(inst, pc);
    exp_q.push_back(exp);
    if (!exp.illegal && exp.rd != 5'd0) begin
        model_regs[exp.rd] = exp.data;
    end
endtask

task automatic issue(input word_t inst);
    send_inst(inst, pc_next);
    pc_next += 32'd4;
endtask

task automatic load_reg(input reg_idx_t rd, input word_t v);
    issue(enc_1ri20(op_lu12i_w, rd, v[31:12]));
    issue(enc_2ri12(op_ori, rd, rd, v[11:0]));
endtask

task automatic drain();
    @(posedge clk_i);
    inst_valid_i <= 1'b0;
    while (exp_q.size() != 0) begin
        @(posedge clk_i);
    end
endtask

task automatic begin_test(input string name);
    cur_test = name;
    err_start = err_count;
    chk_start = res_checked;
endtask

task automatic end_test();
    drain();
    tests_run++;
    $display("%s: %0d results checked, %0d errors", cur_test, res_checked - chk_start,
             err_count - err_start);
endtask

task automatic muldiv_pair(input word_t a, input word_t b);
    load_reg(1, a);
    load_reg(2, b);
    issue(enc_3r(op_mul_w, 3, 1, 2));
    issue(enc_3r(op_mulh_w, 4, 1, 2));
    issue(enc_3r(op_mulh_wu, 5, 1, 2));
    issue(enc_3r(op_div_w, 6, 1, 2));
    issue(enc_3r(op_mod_w, 7, 1, 2));
    issue(enc_3r(op_div_wu, 8, 1, 2));
    issue(enc_3r(op_mod_wu, 9, 1, 2));
endtask

always @(posedge clk_i) begin : compare
    result_t got;
    result_t exp;
    got = '{rd: res_rd_o, data: res_data_o, pc: res_pc_o, illegal: res_illegal_o};
    if (rst_n_i) begin
        if (inst_credit_o) begin
            credit_ret++;
        end
        if (res_credit_i) begin
            res_ret++;
        end
        if (res_valid_o) begin
            res_seen++;
            owed++;
            if (exp_q.size() == 0) begin
                $display("%s: a result arrived with no instruction outstanding", cur_test);
                err_count++;
            end else begin
                exp = exp_q.pop_front();
                check_result(exp, got);
            end
            if (res_seen - res_ret > `_OUT_CREDITS) begin
                $display("%s: more results outstanding than the consumer has room for",
                         cur_test);
                err_count++;
            end
        end
    end
end

// Consumer frees one slot per credit pulse, after a short random gap
initial begin : consumer
    int gap;
    forever begin
        @(posedge clk_i);
        res_credit_i <= 1'b0;
        if (owed > 0 && !hold_credits) begin
            gap = $unsigned($random(gap_seed)) % 4;
            repeat (gap) @(posedge clk_i);
            res_credit_i <= 1'b1;
            owed--;
        end
    end
end

always @(posedge clk_i) begin
    cycles++;
    if (cycles > 40 * credit_used + 100) begin
        $display("Timeout after %0d cycles with %0d results still missing", cycles,
                 exp_q.size());
        $display("STATUS: FAIL");
        $finish;
    end
end

initial begin
    word_t v;
    word_t imm;
    int    seen_start;
    stim_seed = 32'hdad9;
    gap_seed = 32'hdad9;
    credit_used = 0;
    credit_ret = 0;
    res_seen = 0;
    res_ret = 0;
    owed = 0;
    cycles = 0;
    err_count = 0;
    res_checked = 0;
    tests_run = 0;
    hold_credits = 1'b0;
    pc_next = 32'h1c00_0000;
    for (int i = 0; i < `_NREG; i++) begin
        model_regs[i] = '0;
    end
    rst_n_i = 1'b0;
    inst_valid_i = 1'b0;
    inst_i = '0;
    pc_i = '0;
    res_credit_i = 1'b0;
    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;

    begin_test("reset");
    @(posedge clk_i);
    if (inst_credit_o !== 1'b0) begin
        $display("ERR %s inst_credit_o: expected 0, actual %b", cur_test, inst_credit_o);
        err_count++;
    end
    if (res_valid_o !== 1'b0) begin
        $display("ERR %s res_valid_o: expected 0, actual %b", cur_test, res_valid_o);
        err_count++;
    end
    issue(enc_3r(op_add_w, 1, 0, 0));
    issue(enc_3r(op_add_w, 2, 3, 4));
    issue(enc_3r(op_or, 5, 31, 0));
    end_test();

    begin_test("forwarding");
    issue(enc_2ri12(op_addi_w, 1, 0, 12'h123));
    issue(enc_2ri12(op_addi_w, 2, 0, 12'hffb));
    issue(enc_3r(op_add_w, 3, 1, 2));
    issue(enc_3r(op_sub_w, 4, 3, 1));
    issue(enc_3r(op_slt, 5, 2, 1));
    issue(enc_3r(op_sltu, 6, 2, 1));
    issue(enc_3r(op_nor, 7, 4, 2));
    issue(enc_3r(op_and, 8, 7, 3));
    issue(enc_3r(op_or, 9, 8, 2));
    issue(enc_3r(op_xor, 10, 9, 9));
    // Shift amount 36 uses only its low five bits
    issue(enc_2ri12(op_addi_w, 11, 0, 12'h024));
    issue(enc_3r(op_sll_w, 12, 2, 11));
    issue(enc_3r(op_srl_w, 13, 2, 11));
    issue(enc_3r(op_sra_w, 14, 2, 11));
    for (int n = 0; n < 3; n++) begin
        load_reg(20, rand_word());
        load_reg(21, rand_word());
        issue(enc_3r(op_add_w, 22, 20, 21));
        issue(enc_3r(op_sub_w, 23, 22, 21));
        issue(enc_3r(op_slt, 24, 23, 20));
        issue(enc_3r(op_sltu, 25, 21, 23));
        issue(enc_3r(op_xor, 26, 23, 22));
        issue(enc_3r(op_sra_w, 27, 26, 21));
        issue(enc_3r(op_srl_w, 28, 26, 20));
        issue(enc_3r(op_sll_w, 29, 28, 23));
    end
    end_test();

    begin_test("immediate");
    for (int n = 0; n < 4; n++) begin
        v = rand_word();
        imm = rand_word();
        load_reg(1, v);
        issue(enc_3r(op_slli_w, 2, 1, imm[4:0]));
        issue(enc_3r(op_srli_w, 3, 1, imm[9:5]));
        issue(enc_3r(op_srai_w, 4, 1, imm[14:10]));
        issue(enc_2ri12(op_slti, 5, 4, imm[11:0]));
        issue(enc_2ri12(op_sltui, 6, 1, imm[23:12]));
        issue(enc_2ri12(op_addi_w, 7, 4, imm[31:20]));
        issue(enc_2ri12(op_andi, 8, 7, imm[11:0]));
        issue(enc_2ri12(op_ori, 9, 8, imm[21:10]));
        issue(enc_2ri12(op_xori, 10, 9, imm[15:4]));
        issue(enc_1ri20(op_lu12i_w, 11, imm[19:0]));
        send_inst(enc_1ri20(op_pcaddu12i, 12, imm[31:12]), rand_word() & 32'hffff_fffc);
    end
    end_test();

    begin_test("muldiv");
    muldiv_pair(rand_word(), rand_word());
    muldiv_pair(rand_word(), rand_word());
    muldiv_pair(rand_word(), 32'd0);
    muldiv_pair(32'h8000_0000, 32'hffff_ffff);
    muldiv_pair(32'h8000_0000, 32'd0);
    muldiv_pair(32'hffff_fff9, 32'd2);
    muldiv_pair(32'd7, 32'hffff_fffe);
    muldiv_pair(32'hffff_ffff, 32'd3);
    end_test();

    begin_test("backpressure");
    while (owed != 0) begin
        @(posedge clk_i);
    end
    @(posedge clk_i);
    hold_credits = 1'b1;
    seen_start = res_seen;
    for (int n = 0; n < 6; n++) begin
        issue(enc_2ri12(op_addi_w, 5'(n + 1), 5'(n), 12'(n * 3 + 1)));
    end
    @(posedge clk_i);
    inst_valid_i <= 1'b0;
    // Observation window long enough for the whole burst to reach writeback
    repeat (30) @(posedge clk_i);
    if (res_seen - seen_start != `_OUT_CREDITS) begin
        $display("ERR %s results while credits withheld: expected %0d, actual %0d",
                 cur_test, `_OUT_CREDITS, res_seen - seen_start);
        err_count++;
    end
    hold_credits = 1'b0;
    drain();
    if (credit_ret != credit_used) begin
        $display("ERR %s input credits returned: expected %0d, actual %0d",
                 cur_test, credit_used, credit_ret);
        err_count++;
    end
    end_test();

    begin_test("illegal");
    load_reg(5, rand_word());
    issue(32'h0000_0000);
    issue(enc_3r(17'h00023, 5, 1, 2));
    issue(32'hffff_ffe5);
    issue(enc_3r(op_add_w, 6, 5, 0));
    issue(enc_3r(op_or, 7, 0, 5));
    end_test();

    $display("Ran %0d tests, checked %0d results, %0d errors", tests_run, res_checked,
             err_count);
    if (err_count == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule

// ==== logic/la_exec_top.sv ====
`timescale 1ns/1ps
`include "la_consts.svh"

module la_exec_top import la_pipe_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     inst_valid_i,
    input  word_t    inst_i,
    input  word_t    pc_i,
    output logic     inst_credit_o,
    input  logic     res_credit_i,
    output logic     res_valid_o,
    output reg_idx_t res_rd_o,
    output word_t    res_data_o,
    output word_t    res_pc_o,
    output logic     res_illegal_o
);

inst_pkt_t in_pkt;
inst_pkt_t head;
logic      head_ready;
logic      pop;
reg_idx_t  raddr0;
reg_idx_t  raddr1;
word_t     rdata0;
word_t     rdata1;
word_t     alu_res;
logic      wen;
reg_idx_t  waddr;
word_t     wdata;
result_t   res;
result_t   fwd_wb;

exe_if exe ();

assign in_pkt        = '{inst: inst_i, pc: pc_i};
assign res_rd_o      = res.rd;
assign res_data_o    = res.data;
assign res_pc_o      = res.pc;
assign res_illegal_o = res.illegal;

credit_fifo #(
    .payload_t (inst_pkt_t),
    .DEPTH     (`_IN_DEPTH)
) i_in_fifo (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .push_i      (inst_valid_i),
    .push_data_i (in_pkt),
    .pop_i       (pop),
    .head_o      (head),
    .ready_o     (head_ready),
    .credit_o    (inst_credit_o)
);

decode_stage i_decode (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .head_i    (head),
    .ready_i   (head_ready),
    .pop_o     (pop),
    .raddr0_o  (raddr0),
    .raddr1_o  (raddr1),
    .rdata0_i  (rdata0),
    .rdata1_i  (rdata1),
    .fwd_alu_i (alu_res),
    .fwd_wb_i  (fwd_wb),
    .exe       (exe.producer)
);

reg_file i_reg_file (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .raddr0_i (raddr0),
    .raddr1_i (raddr1),
    .rdata0_o (rdata0),
    .rdata1_o (rdata1),
    .wen_i    (wen),
    .waddr_i  (waddr),
    .wdata_i  (wdata)
);

alu i_alu (
    .exe       (exe.consumer),
    .alu_res_o (alu_res)
);

exec_stage i_exec (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .exe          (exe.consumer),
    .alu_res_i    (alu_res),
    .res_credit_i (res_credit_i),
    .res_valid_o  (res_valid_o),
    .res_o        (res),
    .wen_o        (wen),
    .waddr_o      (waddr),
    .wdata_o      (wdata),
    .fwd_wb_o     (fwd_wb)
);

endmodule

// ==== logic/exec_stage.sv ====
`timescale 1ns/1ps
`include "la_consts.svh"

module exec_stage import la_pipe_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    exe_if.consumer  exe,
    input  word_t    alu_res_i,
    input  logic     res_credit_i,
    output logic     res_valid_o,
    output result_t  res_o,
    output logic     wen_o,
    output reg_idx_t waddr_o,
    output word_t    wdata_o,
    output result_t  fwd_wb_o
);

localparam int CW = $clog2(`_OUT_CREDITS + 1);

logic          wb_valid;
result_t       wb;
logic [CW-1:0] credits;
logic          wb_stall;

assign wb_stall    = wb_valid && credits == '0;
assign exe.stall   = exe.valid && wb_stall;
assign res_valid_o = wb_valid && credits != '0;
assign res_o       = wb;

// The register file is written only when the result leaves
assign wen_o    = res_valid_o;
assign waddr_o  = wb.rd;
assign wdata_o  = wb.data;
assign fwd_wb_o = wb_valid ? wb : '0;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        wb_valid <= 1'b0;
        credits  <= CW'(`_OUT_CREDITS);
    end else begin
        credits <= credits - CW'(res_valid_o) + CW'(res_credit_i);
        if (!wb_stall) begin
            wb_valid <= exe.valid;
        end
    end
end

always_ff @(posedge clk_i) begin
    if (!wb_stall) begin
        wb.rd      <= exe.info.general.wen ? exe.info.general.rd : 5'd0;
        wb.data    <= alu_res_i;
        wb.pc      <= exe.pc;
        wb.illegal <= exe.info.general.illegal;
    end
end

a_credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits <= CW'(`_OUT_CREDITS))
    else $error("exec_stage: output credits above limit");

// The consumer frees only slots that hold a result
a_credit_owed: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_credit_i |-> credits != CW'(`_OUT_CREDITS) || res_valid_o)
    else $error("exec_stage: credit returned with no result outstanding");

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`include "la_consts.svh"

module alu import la_decode_pkg::*, la_pipe_pkg::*; (
    exe_if.consumer exe,
    output word_t   alu_res_o
);

alu_type_t     alu_type;
opd_type_t     opd_type;
opd_unsigned_t opd_unsigned;
inst25_0_t     inst25_0;
word_t         opd1;
word_t         opd2;
logic [63:0]   product;
logic [63:0]   productu;
logic          div_zero;
logic          div_ovf;

assign alu_type     = exe.info.ex.alu_type;
assign opd_type     = exe.info.ex.opd_type;
assign opd_unsigned = exe.info.ex.opd_unsigned;
assign inst25_0     = exe.info.general.inst25_0;

always_comb begin
    opd1 = exe.opd[0];
    case (opd_type)
        `_OPD_IMM_U5: opd2 = {27'd0, inst25_0[14:10]};
        `_OPD_IMM_S12: opd2 = {{20{inst25_0[21]}}, inst25_0[21:10]};
        `_OPD_IMM_U12: opd2 = {20'd0, inst25_0[21:10]};
        `_OPD_IMM_S20: begin
            // pcaddu12i adds the shifted immediate to the PC
            if (alu_type == `_ALU_TYPE_ADD) begin
                opd1 = exe.pc;
            end
            opd2 = {inst25_0[24:5], 12'd0};
        end
        default: opd2 = exe.opd[1];
    endcase
end

assign productu = opd1 * opd2;
assign product  = $signed(opd1) * $signed(opd2);
assign div_zero = opd2 == '0;
assign div_ovf  = !opd_unsigned && opd1 == 32'h8000_0000 && opd2 == 32'hffff_ffff;

always_comb begin
    alu_res_o = '0;
    case (alu_type)
        `_ALU_TYPE_ADD: alu_res_o = opd1 + opd2;
        `_ALU_TYPE_SUB: alu_res_o = opd1 - opd2;
        `_ALU_TYPE_SLT: begin
            if (opd_unsigned) begin
                alu_res_o[0] = opd1 < opd2;
            end else begin
                alu_res_o[0] = $signed(opd1) < $signed(opd2);
            end
        end
        `_ALU_TYPE_AND: alu_res_o = opd1 & opd2;
        `_ALU_TYPE_OR: alu_res_o = opd1 | opd2;
        `_ALU_TYPE_XOR: alu_res_o = opd1 ^ opd2;
        `_ALU_TYPE_NOR: alu_res_o = ~(opd1 | opd2);
        `_ALU_TYPE_SL: alu_res_o = opd1 << opd2[4:0];
        `_ALU_TYPE_SR: begin
            if (opd_unsigned) begin
                alu_res_o = opd1 >> opd2[4:0];
            end else begin
                alu_res_o = $signed(opd1) >>> opd2[4:0];
            end
        end
        `_ALU_TYPE_MUL: alu_res_o = product[31:0];
        `_ALU_TYPE_MULH: alu_res_o = opd_unsigned ? productu[63:32] : product[63:32];
        `_ALU_TYPE_DIV: begin
            if (div_zero) begin
                alu_res_o = '1;
            end else if (div_ovf) begin
                alu_res_o = 32'h8000_0000;
            end else if (opd_unsigned) begin
                alu_res_o = opd1 / opd2;
            end else begin
                alu_res_o = $signed(opd1) / $signed(opd2);
            end
        end
        `_ALU_TYPE_MOD: begin
            if (div_zero) begin
                alu_res_o = opd1;
            end else if (div_ovf) begin
                alu_res_o = '0;
            end else if (opd_unsigned) begin
                alu_res_o = opd1 % opd2;
            end else begin
                alu_res_o = $signed(opd1) % $signed(opd2);
            end
        end
        `_ALU_TYPE_LUI: alu_res_o = opd2;
        default: alu_res_o = '0;
    endcase
    if (exe.info.general.illegal) begin
        alu_res_o = '0;
    end
end

endmodule

// ==== logic/decode_stage.sv ====
`timescale 1ns/1ps
`include "la_consts.svh"

module decode_stage import la_decode_pkg::*, la_pipe_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_n_i,
    input  inst_pkt_t head_i,
    input  logic      ready_i,
    output logic      pop_o,
    output reg_idx_t  raddr0_o,
    output reg_idx_t  raddr1_o,
    input  word_t     rdata0_i,
    input  word_t     rdata1_i,
    input  word_t     fwd_alu_i,
    input  result_t   fwd_wb_i,
    exe_if.producer   exe
);

word_t        inst;
decode_info_t dec;
reg_idx_t     exe_rd;
word_t        opd0;
word_t        opd1;

assign inst = head_i.inst;

always_comb begin
    dec = '0;
    dec.general.inst25_0 = inst[25:0];
    dec.general.rd = inst[4:0];
    dec.general.rj = inst[9:5];
    dec.general.rk = inst[14:10];
    dec.general.wen = 1'b1;
    casez (inst[31:15])
        17'h00020: dec.ex = '{`_ALU_TYPE_ADD, `_OPD_REG, 1'b0};
        17'h00022: dec.ex = '{`_ALU_TYPE_SUB, `_OPD_REG, 1'b0};
        17'h00024: dec.ex = '{`_ALU_TYPE_SLT, `_OPD_REG, 1'b0};
        17'h00025: dec.ex = '{`_ALU_TYPE_SLT, `_OPD_REG, 1'b1};
        17'h00028: dec.ex = '{`_ALU_TYPE_NOR, `_OPD_REG, 1'b0};
        17'h00029: dec.ex = '{`_ALU_TYPE_AND, `_OPD_REG, 1'b0};
        17'h0002a: dec.ex = '{`_ALU_TYPE_OR, `_OPD_REG, 1'b0};
        17'h0002b: dec.ex = '{`_ALU_TYPE_XOR, `_OPD_REG, 1'b0};
        17'h0002e: dec.ex = '{`_ALU_TYPE_SL, `_OPD_REG, 1'b0};
        17'h0002f: dec.ex = '{`_ALU_TYPE_SR, `_OPD_REG, 1'b1};
        17'h00030: dec.ex = '{`_ALU_TYPE_SR, `_OPD_REG, 1'b0};
        17'h00038: dec.ex = '{`_ALU_TYPE_MUL, `_OPD_REG, 1'b0};
        17'h00039: dec.ex = '{`_ALU_TYPE_MULH, `_OPD_REG, 1'b0};
        17'h0003a: dec.ex = '{`_ALU_TYPE_MULH, `_OPD_REG, 1'b1};
        17'h00040: dec.ex = '{`_ALU_TYPE_DIV, `_OPD_REG, 1'b0};
        17'h00041: dec.ex = '{`_ALU_TYPE_MOD, `_OPD_REG, 1'b0};
        17'h00042: dec.ex = '{`_ALU_TYPE_DIV, `_OPD_REG, 1'b1};
        17'h00043: dec.ex = '{`_ALU_TYPE_MOD, `_OPD_REG, 1'b1};
        17'h00081: dec.ex = '{`_ALU_TYPE_SL, `_OPD_IMM_U5, 1'b0};
        17'h00089: dec.ex = '{`_ALU_TYPE_SR, `_OPD_IMM_U5, 1'b1};
        17'h00091: dec.ex = '{`_ALU_TYPE_SR, `_OPD_IMM_U5, 1'b0};
        // The 12-bit immediate forms carry their opcode in bits 31:22
        17'b0000001000_???????: dec.ex = '{`_ALU_TYPE_SLT, `_OPD_IMM_S12, 1'b0};
        17'b0000001001_???????: dec.ex = '{`_ALU_TYPE_SLT, `_OPD_IMM_S12, 1'b1};
        17'b0000001010_???????: dec.ex = '{`_ALU_TYPE_ADD, `_OPD_IMM_S12, 1'b0};
        17'b0000001101_???????: dec.ex = '{`_ALU_TYPE_AND, `_OPD_IMM_U12, 1'b0};
        17'b0000001110_???????: dec.ex = '{`_ALU_TYPE_OR, `_OPD_IMM_U12, 1'b0};
        17'b0000001111_???????: dec.ex = '{`_ALU_TYPE_XOR, `_OPD_IMM_U12, 1'b0};
        // lu12i.w and pcaddu12i carry their opcode in bits 31:25
        17'b0001010_??????????: dec.ex = '{`_ALU_TYPE_LUI, `_OPD_IMM_S20, 1'b0};
        17'b0001110_??????????: dec.ex = '{`_ALU_TYPE_ADD, `_OPD_IMM_S20, 1'b0};
        default: begin
            dec.general.rd = 5'd0;
            dec.general.wen = 1'b0;
            dec.general.illegal = 1'b1;
        end
    endcase
end

assign raddr0_o = dec.general.rj;
assign raddr1_o = dec.general.rk;

// The instruction in execute shows destination zero when nothing forwards from it
assign exe_rd = (exe.valid && exe.info.general.wen) ? exe.info.general.rd : 5'd0;

// Newest producer wins; an empty writeback slot shows rd zero
function automatic word_t fwd_sel(input reg_idx_t src, input word_t rf_data);
    if (src == 5'd0) begin
        return rf_data;
    end else if (exe_rd == src) begin
        return fwd_alu_i;
    end else if (fwd_wb_i.rd == src) begin
        return fwd_wb_i.data;
    end
    return rf_data;
endfunction

always_comb begin
    opd0 = fwd_sel(raddr0_o, rdata0_i);
    opd1 = fwd_sel(raddr1_o, rdata1_i);
end

assign pop_o = ready_i && !exe.stall;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        exe.valid <= 1'b0;
    end else if (!exe.stall) begin
        exe.valid <= pop_o;
    end
end

always_ff @(posedge clk_i) begin
    if (!exe.stall) begin
        exe.info   <= dec;
        exe.opd[0] <= opd0;
        exe.opd[1] <= opd1;
        exe.pc     <= head_i.pc;
    end
end

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps
`include "la_consts.svh"

module reg_file import la_pipe_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  reg_idx_t raddr0_i,
    input  reg_idx_t raddr1_i,
    output word_t    rdata0_o,
    output word_t    rdata1_o,
    input  logic     wen_i,
    input  reg_idx_t waddr_i,
    input  word_t    wdata_i
);

word_t regs [`_NREG];
logic  wr_live;

// r0 is never written, so it keeps its reset value of zero
assign wr_live = wen_i && waddr_i != '0;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        for (int i = 0; i < `_NREG; i++) begin
            regs[i] <= '0;
        end
    end else if (wr_live) begin
        regs[waddr_i] <= wdata_i;
    end
end

// Write-through so a read in the write cycle already sees the new value
assign rdata0_o = (wr_live && waddr_i == raddr0_i) ? wdata_i : regs[raddr0_i];
assign rdata1_o = (wr_live && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];

endmodule

// ==== logic/credit_fifo.sv ====
`timescale 1ns/1ps

module credit_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t head_o,
    output logic     ready_o,
    output logic     credit_o
);

localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CW = $clog2(DEPTH + 1);

payload_t      mem [DEPTH];
logic [AW-1:0] wr_ptr;
logic [AW-1:0] rd_ptr;
logic [CW-1:0] count;
logic          do_pop;

function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
endfunction

assign ready_o  = count != '0;
assign head_o   = mem[rd_ptr];
assign do_pop   = pop_i && ready_o;
// Every entry that leaves hands one credit back to the sender
assign credit_o = do_pop;

always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (push_i) begin
            wr_ptr <= next_ptr(wr_ptr);
        end
        if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
        end
        count <= count + CW'(push_i) - CW'(do_pop);
    end
end

always_ff @(posedge clk_i) begin
    if (push_i) begin
        mem[wr_ptr] <= push_data_i;
    end
end

// The sender pushed without holding a credit
a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> count != CW'(DEPTH))
    else $error("credit_fifo: push while full");

a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> ready_o)
    else $error("credit_fifo: pop while empty");

endmodule

// ==== logic/exe_if.sv ====
`timescale 1ns/1ps

interface exe_if import la_decode_pkg::*, la_pipe_pkg::*; ();

logic         valid;
decode_info_t info;
// Index 0 comes from rj, index 1 from rk
word_t [1:0]  opd;
word_t        pc;
logic         stall;

modport producer (
    output valid, info, opd, pc,
    input  stall
);

modport consumer (
    input  valid, info, opd, pc,
    output stall
);

endinterface

// ==== logic/la_pipe_pkg.sv ====
package la_pipe_pkg;

    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] word_t;

    typedef struct packed {
        word_t inst;
        word_t pc;
    } inst_pkt_t;

    typedef struct packed {
        reg_idx_t rd;
        word_t    data;
        word_t    pc;
        logic     illegal;
    } result_t;

endpackage

// ==== logic/la_decode_pkg.sv ====
package la_decode_pkg;

    typedef logic [3:0]  alu_type_t;
    typedef logic [2:0]  opd_type_t;
    typedef logic        opd_unsigned_t;
    typedef logic [25:0] inst25_0_t;

    // Fields used only by the ALU
    typedef struct packed {
        alu_type_t     alu_type;
        opd_type_t     opd_type;
        opd_unsigned_t opd_unsigned;
    } ex_info_t;

    // Register fields and flags that travel with the instruction
    typedef struct packed {
        inst25_0_t  inst25_0;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        logic       wen;
        logic       illegal;
    } general_info_t;

    typedef struct packed {
        ex_info_t      ex;
        general_info_t general;
    } decode_info_t;

endpackage

// ==== logic/la_consts.svh ====
`ifndef LA_CONSTS_SVH
`define LA_CONSTS_SVH

// ALU operation codes
`define _ALU_TYPE_ADD   4'd0
`define _ALU_TYPE_SUB   4'd1
`define _ALU_TYPE_SLT   4'd2
`define _ALU_TYPE_AND   4'd3
`define _ALU_TYPE_OR    4'd4
`define _ALU_TYPE_XOR   4'd5
`define _ALU_TYPE_NOR   4'd6
`define _ALU_TYPE_SL    4'd7
`define _ALU_TYPE_SR    4'd8
`define _ALU_TYPE_MUL   4'd9
`define _ALU_TYPE_MULH  4'd10
`define _ALU_TYPE_DIV   4'd11
`define _ALU_TYPE_MOD   4'd12
`define _ALU_TYPE_LUI   4'd13

// Source of the second ALU operand
`define _OPD_REG        3'd0
`define _OPD_IMM_U5     3'd1
`define _OPD_IMM_S12    3'd2
`define _OPD_IMM_U12    3'd3
`define _OPD_IMM_S20    3'd4

`define _IN_DEPTH       4
`define _OUT_CREDITS    2
`define _NREG           32

`endif
